// File: dv/uart_cmd_hub_tb.sv
`timescale 1ns/1ns
`default_nettype none

module uart_cmd_hub_tb
  import uart_hub_pkg::*;
();

  localparam int NUM_LINKS    = 4;
  localparam int BIT_CYCLES   = 8;
  localparam int GAP_CYCLES   = 12;
  localparam int RESP_TIMEOUT = 400;
  localparam int CH_W         = $clog2(NUM_LINKS);
  localparam int CLK_NS       = 4;

  // Two frames, gap, full reply window and a reply frame, in clocks.
  localparam int CMD_CYCLES = 33 * BIT_CYCLES + GAP_CYCLES + RESP_TIMEOUT + 64;
  localparam int WAIT_LIMIT = 3 * CMD_CYCLES;
  localparam int NUM_CMDS   = 2 * NUM_LINKS + NUM_LINKS + 2 * NUM_LINKS + 2 + NUM_LINKS + 2;
  localparam longint WATCHDOG_NS = 2 * (longint'(NUM_CMDS) * CMD_CYCLES + 2000) * CLK_NS;

  localparam logic [1:0] MODE_NORMAL   = 2'd0;
  localparam logic [1:0] MODE_BAD_PAR  = 2'd1;
  localparam logic [1:0] MODE_BAD_STOP = 2'd2;
  localparam logic [1:0] MODE_SILENT   = 2'd3;

  logic                 clk;
  logic                 rst_n;
  cmd_word_u            cmd_in;
  logic [CH_W-1:0]      cmd_chan;
  logic                 cmd_vld;
  wire                  cmd_rdy;
  wire [NUM_LINKS-1:0]  rx_line;
  wire [NUM_LINKS-1:0]  tx_line;
  wire                  read_vld;
  wire [DATA_W-1:0]     read_data;
  wire [CH_W-1:0]       read_chan;
  wire [STAT_W-1:0]     read_status;

  logic [1:0]           reply_mode [NUM_LINKS];
  cmd_word_u            got_word   [NUM_LINKS];
  int                   got_cnt    [NUM_LINKS];
  int                   got_errs   [NUM_LINKS];

  logic [DATA_W-1:0]    rd_data_q [$];
  logic [CH_W-1:0]      rd_chan_q [$];
  logic [STAT_W-1:0]    rd_stat_q [$];

  logic [31:0]          lfsr = 32'hf42a;
  int                   errors;
  int                   tests_run;
  int                   tests_bad;

  uart_cmd_hub #(
    .NUM_LINKS    (NUM_LINKS),
    .BIT_CYCLES   (BIT_CYCLES),
    .GAP_CYCLES   (GAP_CYCLES),
    .RESP_TIMEOUT (RESP_TIMEOUT)
  ) uart_cmd_hub_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_in      (cmd_in),
    .cmd_chan    (cmd_chan),
    .cmd_vld     (cmd_vld),
    .cmd_rdy     (cmd_rdy),
    .rx          (rx_line),
    .tx          (tx_line),
    .read_vld    (read_vld),
    .read_data   (read_data),
    .read_chan   (read_chan),
    .read_status (read_status)
  );

  for (genvar gi = 0; gi < NUM_LINKS; gi++)
  begin : g_remote
    uart_remote_model #(.BIT_CYCLES(BIT_CYCLES), .LINK(gi)) remote_inst (
      .clk      (clk),
      .line_in  (tx_line[gi]),
      .line_out (rx_line[gi]),
      .mode     (reply_mode[gi]),
      .word     (got_word[gi]),
      .words    (got_cnt[gi]),
      .errs     (got_errs[gi])
    );
  end

  initial
  begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // Read strobes last one cycle, so each is seen at exactly one falling edge.
  always @(negedge clk)
  begin
    if (read_vld === 1'b1)
    begin
      rd_data_q.push_back(read_data);
      rd_chan_q.push_back(read_chan);
      rd_stat_q.push_back(read_status);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return r;
  endfunction

  // Contents the remote device holds at each address.
  function automatic logic [DATA_W-1:0] expected_reply(input int link, input logic [6:0] addr);
    return 8'(int'(addr) * 29 + link * 71) ^ 8'hc3;
  endfunction

  task automatic check_word(input string what, input cmd_word_u got, input cmd_word_u exp);
    if (got !== exp)
    begin
      $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_byte(input string what, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp)
    begin
      $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_status(input string what, input logic [STAT_W-1:0] got,
                              input logic [STAT_W-1:0] exp);
    if (got !== exp)
    begin
      $display("error %0t: %s status is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp)
    begin
      $display("error %0t: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic send_cmd(input cmd_word_u c, input int ch);
    int n;
    n        = 0;
    cmd_in   = c;
    cmd_chan = CH_W'(ch);
    cmd_vld  = 1'b1;
    while (!cmd_rdy && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (!cmd_rdy)
    begin
      $display("The hub never accepted a command for link %0d.", ch);
      errors++;
    end
    @(negedge clk);                      // Accepted on the edge before this.
    cmd_vld = 1'b0;
  endtask

  task automatic wait_reads(input int count);
    int n;
    n = 0;
    while (rd_data_q.size() < count && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (rd_data_q.size() < count)
    begin
      $display("Only %0d of %0d read results came out of the read port.",
               rd_data_q.size(), count);
      errors++;
    end
  endtask

  function automatic cmd_word_u random_cmd(input logic rw);
    cmd_word_u c;
    c.fields.rw   = rw;
    c.fields.addr = 7'(rand_bits(7));
    c.fields.data = 8'(rand_bits(8));
    return c;
  endfunction

  // One read on one link, checked against the remote memory.
  task automatic read_and_check(input string what, input int ch,
                                input logic [STAT_W-1:0] exp_stat);
    cmd_word_u c;
    c = random_cmd(1'b0);
    send_cmd(c, ch);
    wait_reads(1);
    if (rd_data_q.size() > 0)
    begin
      check_count({what, " read_chan"}, rd_chan_q.pop_front(), ch);
      check_status(what, rd_stat_q.pop_front(), exp_stat);
      if (exp_stat == STAT_TIMEOUT)
        void'(rd_data_q.pop_front());
      else
        check_byte({what, " read_data"}, rd_data_q.pop_front(), expected_reply(ch, c.fields.addr));
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before)
      $display("test %-12s ok", name);
    else
    begin
      tests_bad++;
      $display("test %-12s FAILED with %0d errors", name, errors - err_before);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic test_write();
    int        err0;
    int        base;
    int        n;
    cmd_word_u c;
    err0 = errors;
    for (int ch = 0; ch < NUM_LINKS; ch++)
    begin
      for (int k = 0; k < 2; k++)
      begin
        c    = random_cmd(1'b1);
        base = got_cnt[ch];
        n    = 0;
        send_cmd(c, ch);
        while (got_cnt[ch] == base && n < WAIT_LIMIT)
        begin
          @(negedge clk);
          n++;
        end
        check_count("write words at remote", got_cnt[ch], base + 1);
        check_word("write word at remote", got_word[ch], c);
        check_count("remote frame errors", got_errs[ch], 0);
      end
    end
    repeat (4 * 11 * BIT_CYCLES) @(negedge clk);
    check_count("read strobes after writes", rd_data_q.size(), 0);
    finish_test("write", err0);
  endtask

  task automatic test_read();
    int err0;
    err0 = errors;
    for (int ch = 0; ch < NUM_LINKS; ch++)
      read_and_check("normal read", ch, STAT_OK);
    finish_test("read", err0);
  endtask

  task automatic test_reply_errors();
    int err0;
    err0 = errors;
    for (int ch = 0; ch < NUM_LINKS; ch++)
    begin
      reply_mode[ch] = MODE_BAD_PAR;
      read_and_check("bad parity", ch, STAT_PARITY);
      reply_mode[ch] = MODE_BAD_STOP;
      read_and_check("bad stop", ch, STAT_FRAME);
      reply_mode[ch] = MODE_NORMAL;
    end
    finish_test("reply_errors", err0);
  endtask

  task automatic test_timeout();
    int err0;
    err0 = errors;
    reply_mode[2] = MODE_SILENT;
    read_and_check("silent", 2, STAT_TIMEOUT);
    reply_mode[2] = MODE_NORMAL;
    read_and_check("after timeout", 2, STAT_OK);
    finish_test("timeout", err0);
  endtask

  task automatic test_concurrency();
    int                err0;
    int                n;
    int                hits;
    int                exp_ch   [NUM_LINKS + 2];
    logic [6:0]        exp_addr [NUM_LINKS + 2];
    bit                used     [NUM_LINKS + 2];
    int                base     [NUM_LINKS];
    cmd_word_u         c;
    logic [CH_W-1:0]   ch;
    logic [DATA_W-1:0] d;
    logic [STAT_W-1:0] s;
    int                j;
    err0 = errors;
    for (int i = 0; i < NUM_LINKS; i++)
      base[i] = got_cnt[i];
    for (int i = 0; i < NUM_LINKS + 2; i++)
    begin
      exp_ch[i] = (i < NUM_LINKS) ? i : i - NUM_LINKS;   // Links 0 and 1 get two.
      used[i]   = 1'b0;
    end
    for (int i = 0; i <= NUM_LINKS; i++)
    begin
      c           = random_cmd(1'b0);
      exp_addr[i] = c.fields.addr;
      send_cmd(c, exp_ch[i]);
    end
    check_count("cmd_rdy with link 0 busy", cmd_rdy, 0);
    n = 0;
    while (!cmd_rdy && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    hits = 0;
    foreach (rd_chan_q[k])
      if (rd_chan_q[k] == 0)
        hits++;
    check_count("link 0 results when cmd_rdy returns", hits, 1);
    c                     = random_cmd(1'b0);
    exp_addr[NUM_LINKS+1] = c.fields.addr;
    send_cmd(c, exp_ch[NUM_LINKS+1]);
    wait_reads(NUM_LINKS + 2);
    repeat (4 * 11 * BIT_CYCLES) @(negedge clk);
    check_count("read results", rd_data_q.size(), NUM_LINKS + 2);
    while (rd_data_q.size() > 0)
    begin
      ch = rd_chan_q.pop_front();
      d  = rd_data_q.pop_front();
      s  = rd_stat_q.pop_front();
      j  = -1;
      for (int i = 0; i < NUM_LINKS + 2; i++)
        if (j < 0 && !used[i] && exp_ch[i] == int'(ch))
          j = i;
      if (j < 0)
      begin
        $display("An extra read result came from link %0d.", ch);
        errors++;
      end
      else
      begin
        used[j] = 1'b1;
        check_byte("concurrent read_data", d, expected_reply(exp_ch[j], exp_addr[j]));
        check_status("concurrent read", s, STAT_OK);
      end
    end
    for (int i = 0; i < NUM_LINKS; i++)
      check_count("commands delivered", got_cnt[i] - base[i], (i < 2) ? 2 : 1);
    finish_test("concurrency", err0);
  endtask

  initial
  begin : watchdog
    #(WATCHDOG_NS);
    $display("The run did not finish within the time allowed for its tests.");
    $display("tests failed");
    $finish;
  end

  initial
  begin
    rst_n    = 1'b0;
    cmd_in   = '0;
    cmd_chan = '0;
    cmd_vld  = 1'b0;
    errors   = 0;
    tests_run = 0;
    tests_bad = 0;
    for (int i = 0; i < NUM_LINKS; i++)
      reply_mode[i] = MODE_NORMAL;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (4) @(negedge clk);
    test_write();
    test_read();
    test_reply_errors();
    test_timeout();
    test_concurrency();
    $display("%0d tests run, %0d with errors, %0d errors in all", tests_run, tests_bad, errors);
    if (tests_bad == 0 && errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/uart_remote_model.sv
`timescale 1ns/1ns
`default_nettype none

module uart_remote_model
  import uart_hub_pkg::*;
#(
  parameter int BIT_CYCLES = 434,
  parameter int LINK       = 0
) (
  input  wire       clk,
  input  wire       line_in,     // From the hub's tx.
  output logic      line_out,    // To the hub's rx.
  input  wire [1:0] mode,        // 0 normal, 1 bad parity, 2 bad stop, 3 silent.
  output cmd_word_u word,
  output int        words,
  output int        errs
);

  logic [DATA_W-1:0] mem [128];

  initial
  begin
    line_out = 1'b1;
    word     = '0;
    words    = 0;
    errs     = 0;
    for (int a = 0; a < 128; a++)
      mem[a] = 8'(a * 29 + LINK * 71) ^ 8'hc3;
  end

  // Samples each bit in its middle, starting from the falling start edge.
  task automatic recv_frame(output logic [DATA_W-1:0] b, output logic ok);
    logic par;
    @(negedge line_in);
    repeat (BIT_CYCLES / 2) @(posedge clk);
    ok = !line_in;
    for (int i = 0; i < DATA_W; i++)
    begin
      repeat (BIT_CYCLES) @(posedge clk);
      b[i] = line_in;
    end
    repeat (BIT_CYCLES) @(posedge clk);
    par = line_in;
    repeat (BIT_CYCLES) @(posedge clk);
    ok = ok && line_in && (par == ~^b);    // Odd parity and a high stop bit.
  endtask

  task automatic send_frame(input logic [DATA_W-1:0] b, input logic bad_par,
                            input logic bad_stop);
    @(negedge clk);
    line_out = 1'b0;
    repeat (BIT_CYCLES) @(negedge clk);
    for (int i = 0; i < DATA_W; i++)
    begin
      line_out = b[i];
      repeat (BIT_CYCLES) @(negedge clk);
    end
    line_out = bad_par ? ^b : ~^b;
    repeat (BIT_CYCLES) @(negedge clk);
    line_out = !bad_stop;
    repeat (BIT_CYCLES) @(negedge clk);
    line_out = 1'b1;
  endtask

  initial
  begin : decode
    cmd_word_u         w;
    logic [DATA_W-1:0] b;
    logic              ok_hi;
    logic              ok_lo;
    forever
    begin
      recv_frame(b, ok_hi);
      w.bytes[1] = b;                      // High byte comes first.
      recv_frame(b, ok_lo);
      w.bytes[0] = b;
      if (!ok_hi || !ok_lo)
        errs++;
      word = w;
      words++;
      if (!w.fields.rw && mode != 2'd3)
      begin
        repeat (2 * BIT_CYCLES) @(posedge clk);
        // Bad stop mode breaks the parity too.
        send_frame(mem[w.fields.addr], mode == 2'd1 || mode == 2'd2, mode == 2'd2);
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/cmd_dispatch.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_dispatch
  import uart_hub_pkg::*;
#(
  parameter int NUM_LINKS = 4
) (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire cmd_word_u              cmd_in,
  input  wire [$clog2(NUM_LINKS)-1:0] cmd_chan,
  input  wire                         cmd_vld,
  input  wire [NUM_LINKS-1:0]         busy,
  output logic                        cmd_rdy,
  output cmd_word_u                   cmd,
  output logic [NUM_LINKS-1:0]        start
);

  logic                         full;
  logic [$clog2(NUM_LINKS)-1:0] chan_q;
  logic                         launch;

  assign cmd_rdy = !full;
  assign launch  = full && !busy[chan_q];

  // One-hot start to the target link.
  always_comb
  begin
    start = '0;
    if (launch)
      start[chan_q] = 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      full <= 1'b0;
    else if (cmd_vld && cmd_rdy)
      full <= 1'b1;
    else if (launch)
      full <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy)
    begin
      cmd    <= cmd_in;
      chan_q <= cmd_chan;
    end
  end

endmodule

`default_nettype wire

// File: hdl/resp_collect.sv
`timescale 1ns/1ns
`default_nettype none

interface resp_if
  import uart_hub_pkg::*;
();
  logic              vld;
  logic [DATA_W-1:0] data;
  logic [STAT_W-1:0] status;
  logic              take;

  modport link    (output vld, data, status, input take);
  modport collect (input vld, data, status, output take);
endinterface

module resp_collect
  import uart_hub_pkg::*;
#(
  parameter int NUM_LINKS = 4
) (
  input  wire                          clk,
  input  wire                          rst_n,
  output logic                         read_vld,
  output logic [DATA_W-1:0]            read_data,
  output logic [$clog2(NUM_LINKS)-1:0] read_chan,
  output logic [STAT_W-1:0]            read_status,
  resp_if.collect                      resp [NUM_LINKS]
);

  localparam int CH_W = $clog2(NUM_LINKS);

  logic [NUM_LINKS-1:0] pend;
  logic [NUM_LINKS-1:0] take_r;
  logic [DATA_W-1:0]    data_arr   [NUM_LINKS];
  logic [STAT_W-1:0]    status_arr [NUM_LINKS];
  logic [CH_W-1:0]      ptr;       // Last link served.
  logic [CH_W-1:0]      pick;
  logic                 found;

  for (genvar gi = 0; gi < NUM_LINKS; gi++)
  begin : g_port
    assign pend[gi]       = resp[gi].vld && !take_r[gi];  // Drops while taking.
    assign data_arr[gi]   = resp[gi].data;
    assign status_arr[gi] = resp[gi].status;
    assign resp[gi].take  = take_r[gi];
  end

  // First pending link after the last one served.
  always_comb
  begin
    int idx;
    found = 1'b0;
    pick  = ptr;
    for (int off = 1; off <= NUM_LINKS; off++)
    begin
      idx = (int'(ptr) + off) % NUM_LINKS;
      if (!found && pend[idx])
      begin
        found = 1'b1;
        pick  = CH_W'(idx);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      read_vld <= 1'b0;
      take_r   <= '0;
      ptr      <= CH_W'(NUM_LINKS - 1);
    end
    else
    begin
      read_vld <= found;
      take_r   <= '0;
      if (found)
      begin
        take_r[pick] <= 1'b1;
        ptr          <= pick;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (found)
    begin
      read_data   <= data_arr[pick];
      read_status <= status_arr[pick];
      read_chan   <= pick;
    end
  end

endmodule

`default_nettype wire

// File: hdl/uart_cmd_hub.sv
`timescale 1ns/1ns
`default_nettype none

module uart_cmd_hub
  import uart_hub_pkg::*;
#(
  parameter int NUM_LINKS    = 4,
  parameter int BIT_CYCLES   = 434,
  parameter int GAP_CYCLES   = 100,
  parameter int RESP_TIMEOUT = 4340
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire [CMD_W-1:0]              cmd_in,
  input  wire [$clog2(NUM_LINKS)-1:0]  cmd_chan,
  input  wire                          cmd_vld,
  output logic                         cmd_rdy,
  input  wire [NUM_LINKS-1:0]          rx,
  output logic [NUM_LINKS-1:0]         tx,
  output logic                         read_vld,
  output logic [DATA_W-1:0]            read_data,
  output logic [$clog2(NUM_LINKS)-1:0] read_chan,
  output logic [STAT_W-1:0]            read_status
);

  cmd_word_u            disp_cmd;   // Shared by all links.
  logic [NUM_LINKS-1:0] link_start;
  logic [NUM_LINKS-1:0] link_busy;

  resp_if resp_bus [NUM_LINKS] ();

  cmd_dispatch #(.NUM_LINKS(NUM_LINKS)) dispatch_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_chan (cmd_chan),
    .cmd_vld  (cmd_vld),
    .busy     (link_busy),
    .cmd_rdy  (cmd_rdy),
    .cmd      (disp_cmd),
    .start    (link_start)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // One engine per UART link.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar gi = 0; gi < NUM_LINKS; gi++)
  begin : g_link
    uart_link #(
      .BIT_CYCLES   (BIT_CYCLES),
      .GAP_CYCLES   (GAP_CYCLES),
      .RESP_TIMEOUT (RESP_TIMEOUT)
    ) link_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .start (link_start[gi]),
      .cmd   (disp_cmd),
      .rx    (rx[gi]),
      .busy  (link_busy[gi]),
      .tx    (tx[gi]),
      .resp  (resp_bus[gi])
    );
  end

  resp_collect #(.NUM_LINKS(NUM_LINKS)) collect_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .read_vld    (read_vld),
    .read_data   (read_data),
    .read_chan   (read_chan),
    .read_status (read_status),
    .resp        (resp_bus)
  );

endmodule

`default_nettype wire

// File: hdl/uart_hub_pkg.sv
`default_nettype none

package uart_hub_pkg;

  localparam int CMD_W  = 16;
  localparam int DATA_W = 8;
  localparam int STAT_W = 2;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Command word, seen as register fields or as the two bytes on the line.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef union packed {
    struct packed {
      logic              rw;    // 1 is a write.
      logic [6:0]        addr;
      logic [DATA_W-1:0] data;
    } fields;
    logic [1:0][DATA_W-1:0] bytes;  // bytes[1] goes out first.
  } cmd_word_u;

  // Reply status.
  localparam logic [STAT_W-1:0] STAT_OK      = 2'd0;
  localparam logic [STAT_W-1:0] STAT_PARITY  = 2'd1;
  localparam logic [STAT_W-1:0] STAT_FRAME   = 2'd2;
  localparam logic [STAT_W-1:0] STAT_TIMEOUT = 2'd3;

endpackage

`default_nettype wire

// File: hdl/uart_link.sv
`timescale 1ns/1ns
`default_nettype none

module uart_link
  import uart_hub_pkg::*;
#(
  parameter int BIT_CYCLES   = 434,
  parameter int GAP_CYCLES   = 100,
  parameter int RESP_TIMEOUT = 4340
) (
  input  wire       clk,
  input  wire       rst_n,
  input  wire       start,
  input  wire       cmd_word_u cmd,
  input  wire       rx,
  output logic      busy,
  output logic      tx,
  resp_if.link      resp
);

  localparam logic [2:0] S_IDLE   = 3'd0;
  localparam logic [2:0] S_FRAME1 = 3'd1;
  localparam logic [2:0] S_GAP    = 3'd2;
  localparam logic [2:0] S_FRAME2 = 3'd3;
  localparam logic [2:0] S_WAIT   = 3'd4;
  localparam logic [2:0] S_RECV   = 3'd5;
  localparam logic [2:0] S_HOLD   = 3'd6;

  localparam int GAP_W = $clog2(GAP_CYCLES + 1);
  localparam int TO_W  = $clog2(RESP_TIMEOUT + 1);

  logic [2:0]        state;
  cmd_word_u         cmd_q;
  logic [GAP_W-1:0]  gap_cnt;
  logic [TO_W-1:0]   to_cnt;
  logic              gap_end;
  logic              timeout;
  logic              tx_load;
  logic [DATA_W-1:0] tx_byte;
  logic              tx_done;
  logic              rx_arm;
  logic              rx_seen;
  logic              rx_done;
  logic [DATA_W-1:0] rx_byte;
  logic              rx_parity_bad;
  logic              rx_stop_bad;
  logic [DATA_W-1:0] data_q;
  logic [STAT_W-1:0] status_q;

  assign gap_end = (state == S_GAP) && (gap_cnt == GAP_W'(GAP_CYCLES - 1));
  assign timeout = (state == S_WAIT) && !rx_seen && (to_cnt == TO_W'(RESP_TIMEOUT - 1));
  assign tx_load = ((state == S_IDLE) && start) || gap_end;
  assign tx_byte = (state == S_IDLE) ? cmd.bytes[1] : cmd_q.bytes[0]; // High byte from input.
  assign rx_arm  = state == S_WAIT;
  assign busy    = state != S_IDLE;

  assign resp.vld    = state == S_HOLD;
  assign resp.data   = data_q;
  assign resp.status = status_q;

  uart_tx_frame #(.BIT_CYCLES(BIT_CYCLES)) tx_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .load    (tx_load),
    .byte_in (tx_byte),
    .tx      (tx),
    .done    (tx_done)
  );

  uart_rx_frame #(.BIT_CYCLES(BIT_CYCLES)) rx_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .arm        (rx_arm),
    .rx         (rx),
    .seen_start (rx_seen),
    .done       (rx_done),
    .byte_out   (rx_byte),
    .parity_bad (rx_parity_bad),
    .stop_bad   (rx_stop_bad)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Command FSM.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= S_IDLE;
      gap_cnt <= '0;
      to_cnt  <= '0;
    end
    else
    begin
      case (state)
        S_IDLE:
          if (start)
            state <= S_FRAME1;
        S_FRAME1:
          if (tx_done)
          begin
            state   <= S_GAP;
            gap_cnt <= '0;
          end
        S_GAP:
          if (gap_end)
            state <= S_FRAME2;
          else
            gap_cnt <= gap_cnt + 1'b1;
        S_FRAME2:
          if (tx_done)
          begin
            state  <= cmd_q.fields.rw ? S_IDLE : S_WAIT;  // Writes end here.
            to_cnt <= '0;
          end
        S_WAIT:
          if (rx_seen)
            state <= S_RECV;
          else if (timeout)
            state <= S_HOLD;
          else
            to_cnt <= to_cnt + 1'b1;
        S_RECV:
          if (rx_done)
            state <= S_HOLD;
        S_HOLD:
          if (resp.take)
            state <= S_IDLE;
        default:
          state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state == S_IDLE) && start)
      cmd_q <= cmd;
    if (timeout)
    begin
      data_q   <= '0;
      status_q <= STAT_TIMEOUT;
    end
    else if ((state == S_RECV) && rx_done)
    begin
      data_q <= rx_byte;
      if (rx_stop_bad)
        status_q <= STAT_FRAME;   // Frame error wins over parity.
      else if (rx_parity_bad)
        status_q <= STAT_PARITY;
      else
        status_q <= STAT_OK;
    end
  end

endmodule

`default_nettype wire

// File: hdl/uart_rx_frame.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx_frame
  import uart_hub_pkg::*;
#(
  parameter int BIT_CYCLES = 434
) (
  input  wire               clk,
  input  wire               rst_n,
  input  wire               arm,
  input  wire               rx,
  output logic              seen_start,
  output logic              done,
  output logic [DATA_W-1:0] byte_out,
  output logic              parity_bad,
  output logic              stop_bad
);

  localparam int CNT_W = $clog2(BIT_CYCLES);

  logic [1:0]        sync;
  logic              rx_prev;
  logic              rcv;
  logic [CNT_W-1:0]  bit_cnt;
  logic [3:0]        bit_idx;
  logic [DATA_W-1:0] shreg;
  logic              par_bit;
  logic              fall;
  logic              mid;
  logic              period_end;

  assign fall       = rx_prev && !sync[1];
  assign seen_start = arm && !rcv && fall;
  assign mid        = rcv && (bit_cnt == CNT_W'(BIT_CYCLES / 2));
  assign period_end = bit_cnt == CNT_W'(BIT_CYCLES - 1);
  assign byte_out   = shreg;

  // Line idles high.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync    <= 2'b11;
      rx_prev <= 1'b1;
    end
    else
    begin
      sync    <= {sync[0], rx};
      rx_prev <= sync[1];
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rcv        <= 1'b0;
      bit_cnt    <= '0;
      bit_idx    <= '0;
      done       <= 1'b0;
      parity_bad <= 1'b0;
      stop_bad   <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      if (seen_start)
      begin
        rcv     <= 1'b1;
        bit_cnt <= '0;
        bit_idx <= '0;
      end
      else if (rcv)
      begin
        bit_cnt <= period_end ? '0 : bit_cnt + 1'b1;
        if (period_end)
          bit_idx <= bit_idx + 4'd1;
        if (mid && bit_idx == 4'd10)
        begin
          rcv        <= 1'b0;      // Stop bit sampled, frame is over.
          done       <= 1'b1;
          stop_bad   <= !sync[1];
          parity_bad <= par_bit != ~^shreg;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (mid && bit_idx >= 4'd1 && bit_idx <= 4'd8)
      shreg <= {sync[1], shreg[DATA_W-1:1]};  // LSB first.
    if (mid && bit_idx == 4'd9)
      par_bit <= sync[1];
  end

endmodule

`default_nettype wire

// File: hdl/uart_tx_frame.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx_frame
  import uart_hub_pkg::*;
#(
  parameter int BIT_CYCLES = 434
) (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              load,
  input  wire [DATA_W-1:0] byte_in,
  output logic             tx,
  output logic             done
);

  localparam int CNT_W = $clog2(BIT_CYCLES);

  logic [CNT_W-1:0] bit_cnt;
  logic [3:0]       bit_idx;   // 0 start, 1..8 data, 9 parity, 10 stop.
  logic             active;
  logic [9:0]       shreg;     // Bits still to go after the current one.
  logic             bit_end;

  assign bit_end = active && (bit_cnt == CNT_W'(BIT_CYCLES - 1));
  assign done    = bit_end && (bit_idx == 4'd10);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active  <= 1'b0;
      bit_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
    end
    else if (load)
    begin
      active  <= 1'b1;
      bit_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b0;            // Start bit.
    end
    else if (bit_end)
    begin
      bit_cnt <= '0;
      if (bit_idx == 4'd10)
      begin
        active <= 1'b0;
        tx     <= 1'b1;
      end
      else
      begin
        bit_idx <= bit_idx + 4'd1;
        tx      <= shreg[0];
      end
    end
    else if (active)
      bit_cnt <= bit_cnt + 1'b1;
  end

  // Odd parity: XNOR of the data bits.
  always_ff @(posedge clk)
  begin
    if (load)
      shreg <= {1'b1, ~^byte_in, byte_in};
    else if (bit_end)
      shreg <= {1'b1, shreg[9:1]};
  end

endmodule

`default_nettype wire

// File: sim.f
hdl/uart_hub_pkg.sv
hdl/uart_tx_frame.sv
hdl/uart_rx_frame.sv
hdl/resp_collect.sv
hdl/uart_link.sv
hdl/cmd_dispatch.sv
hdl/uart_cmd_hub.sv
dv/uart_remote_model.sv
dv/uart_cmd_hub_tb.sv
